// File: design/l1_mem_config.svh
// Fixed widths and depths of the L1 memory bridge
`ifndef L1_MEM_CONFIG_SVH
`define L1_MEM_CONFIG_SVH

// Byte address
`define L1_ADDR_W 32

// Client word and bus beat
`define L1_WORD_W 32
`define AXI_DATA_W 64

// Reads in flight between adapter and AXI slave
`define RD_TRACK_DEPTH 4

`endif

// File: design/l1_mem_pkg.sv
// Shared vector types and write FSM encoding of the L1 memory bridge
`default_nettype none

`include "l1_mem_config.svh"

package l1_mem_pkg;

    // Client side
    typedef logic [`L1_ADDR_W-1:0]     addr_t;
    typedef logic [`L1_WORD_W-1:0]     word_t;
    typedef logic [`L1_WORD_W/8-1:0]   word_strb_t;

    // Bus side
    typedef logic [`AXI_DATA_W-1:0]    beat_t;
    typedef logic [`AXI_DATA_W/8-1:0]  beat_strb_t;

    // 0 is the instruction cache, 1 the data cache
    typedef logic src_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_RESP
    } wr_state_e;

endpackage

`default_nettype wire

// File: design/l1_mem_ifs.sv
// Word and beat request/response channels between the bridge stages
`default_nettype none

// Arbiter to width adapter, 32-bit words tagged with their source
interface mem_word_if;
    logic                    req_valid;
    logic                    req_rw;
    l1_mem_pkg::addr_t       req_addr;
    l1_mem_pkg::word_strb_t  req_byteen;
    l1_mem_pkg::word_t       req_data;
    l1_mem_pkg::src_t        req_src;
    logic                    req_ready;

    logic                    rsp_valid;
    l1_mem_pkg::word_t       rsp_data;
    l1_mem_pkg::src_t        rsp_src;
    logic                    rsp_ready;

    modport arb (
        output req_valid, req_rw, req_addr, req_byteen, req_data, req_src,
        input  req_ready,
        input  rsp_valid, rsp_data, rsp_src,
        output rsp_ready
    );

    modport adapter (
        input  req_valid, req_rw, req_addr, req_byteen, req_data, req_src,
        output req_ready,
        output rsp_valid, rsp_data, rsp_src,
        input  rsp_ready
    );
endinterface

// Width adapter to AXI master, 64-bit beats
interface mem_beat_if;
    logic                    req_valid;
    logic                    req_rw;
    l1_mem_pkg::addr_t       req_addr;
    l1_mem_pkg::beat_strb_t  req_strb;
    l1_mem_pkg::beat_t       req_data;
    logic                    req_ready;

    logic                    rsp_valid;
    l1_mem_pkg::beat_t       rsp_data;
    logic                    rsp_ready;

    modport adapter (
        output req_valid, req_rw, req_addr, req_strb, req_data,
        input  req_ready,
        input  rsp_valid, rsp_data,
        output rsp_ready
    );

    modport master (
        input  req_valid, req_rw, req_addr, req_strb, req_data,
        output req_ready,
        output rsp_valid, rsp_data,
        input  rsp_ready
    );
endinterface

`default_nettype wire

// File: design/l1_mem_arb.sv
// Fixed-priority merge of the instruction and data cache clients
`default_nettype none

module l1_mem_arb (
    // Instruction cache, reads only
    input  wire                     ic_req_valid,
    input  l1_mem_pkg::addr_t       ic_req_addr,
    output logic                    ic_req_ready,
    output logic                    ic_rsp_valid,
    output l1_mem_pkg::word_t       ic_rsp_data,
    input  wire                     ic_rsp_ready,

    // Data cache
    input  wire                     dc_req_valid,
    input  wire                     dc_req_rw,
    input  l1_mem_pkg::addr_t       dc_req_addr,
    input  l1_mem_pkg::word_strb_t  dc_req_byteen,
    input  l1_mem_pkg::word_t       dc_req_data,
    output logic                    dc_req_ready,
    output logic                    dc_rsp_valid,
    output l1_mem_pkg::word_t       dc_rsp_data,
    input  wire                     dc_rsp_ready,

    mem_word_if.arb                 down
);

    //////////////////////////////////////////////////
    // Request side

    // Instruction cache wins whenever it asks
    assign down.req_valid  = ic_req_valid || dc_req_valid;
    assign down.req_src    = l1_mem_pkg::src_t'(!ic_req_valid);
    assign down.req_rw     = ic_req_valid ? 1'b0 : dc_req_rw;
    assign down.req_addr   = ic_req_valid ? ic_req_addr : dc_req_addr;
    assign down.req_byteen = ic_req_valid ? '1 : dc_req_byteen;
    assign down.req_data   = dc_req_data;

    assign ic_req_ready = down.req_ready;
    assign dc_req_ready = down.req_ready && !ic_req_valid;

    //////////////////////////////////////////////////
    // Response side

    // Source tag comes back from the adapter's tracking FIFO
    assign ic_rsp_valid = down.rsp_valid && (down.rsp_src == 1'b0);
    assign dc_rsp_valid = down.rsp_valid && (down.rsp_src == 1'b1);
    assign ic_rsp_data  = down.rsp_data;
    assign dc_rsp_data  = down.rsp_data;

    assign down.rsp_ready = down.rsp_src ? dc_rsp_ready : ic_rsp_ready;

endmodule

`default_nettype wire

// File: design/l1_mem_adapter.sv
// Word to beat lane steering with in-order read lane tracking
`default_nettype none

`include "l1_mem_config.svh"

module l1_mem_adapter (
    input  wire          clk,
    input  wire          arst_n,
    mem_word_if.adapter  up,
    mem_beat_if.adapter  down
);

    // Byte offset bits inside one beat; the top one selects the lane
    localparam int BEAT_OFF = $clog2(`AXI_DATA_W / 8);
    localparam int LANE_BIT = BEAT_OFF - 1;
    localparam int PTR_W    = $clog2(`RD_TRACK_DEPTH);

    logic              lane;
    logic              trk_full;
    logic              trk_push;
    logic              trk_pop;
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [PTR_W:0]    trk_cnt;

    logic              lane_mem [`RD_TRACK_DEPTH];
    l1_mem_pkg::src_t  src_mem  [`RD_TRACK_DEPTH];

    //////////////////////////////////////////////////
    // Request steering

    assign lane = up.req_addr[LANE_BIT];

    // Reads stall when no tracking slot is left
    assign down.req_valid = up.req_valid && !(trk_full && !up.req_rw);
    assign up.req_ready   = down.req_ready && !(trk_full && !up.req_rw);

    assign down.req_rw   = up.req_rw;
    assign down.req_addr = {up.req_addr[`L1_ADDR_W-1:BEAT_OFF], {BEAT_OFF{1'b0}}};
    assign down.req_strb = lane ? {up.req_byteen, {(`L1_WORD_W/8){1'b0}}}
                                : {{(`L1_WORD_W/8){1'b0}}, up.req_byteen};
    assign down.req_data = {2{up.req_data}};

    //////////////////////////////////////////////////
    // Read tracking FIFO

    assign trk_full = (trk_cnt == (PTR_W+1)'(`RD_TRACK_DEPTH));
    assign trk_push = up.req_valid && up.req_ready && !up.req_rw;
    assign trk_pop  = down.rsp_valid && down.rsp_ready;

    always_ff @(posedge clk) begin
        if (trk_push) begin
            lane_mem[wr_ptr] <= lane;
            src_mem[wr_ptr]  <= up.req_src;
        end
    end

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            trk_cnt <= '0;
        end else begin
            if (trk_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (trk_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({trk_push, trk_pop})
                2'b10:   trk_cnt <= trk_cnt + 1'b1;
                2'b01:   trk_cnt <= trk_cnt - 1'b1;
                default: trk_cnt <= trk_cnt;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Response lane select

    assign up.rsp_valid   = down.rsp_valid;
    assign up.rsp_data    = lane_mem[rd_ptr] ? down.rsp_data[`AXI_DATA_W-1:`L1_WORD_W]
                                             : down.rsp_data[`L1_WORD_W-1:0];
    assign up.rsp_src     = src_mem[rd_ptr];
    assign down.rsp_ready = up.rsp_ready;

endmodule

`default_nettype wire

// File: design/axi_lite_master.sv
// AXI4-Lite master with one registered write and a pipelined read slot
`default_nettype none

`include "l1_mem_config.svh"

module axi_lite_master (
    input  wire                     clk,
    input  wire                     arst_n,
    mem_beat_if.master              up,

    // Write address and data
    output logic                    awvalid,
    input  wire                     awready,
    output l1_mem_pkg::addr_t       awaddr,
    output logic                    wvalid,
    input  wire                     wready,
    output l1_mem_pkg::beat_t       wdata,
    output l1_mem_pkg::beat_strb_t  wstrb,

    // Write response, status not checked
    input  wire                     bvalid,
    output logic                    bready,
    input  wire [1:0]               bresp,

    // Read address
    output logic                    arvalid,
    input  wire                     arready,
    output l1_mem_pkg::addr_t       araddr,

    // Read response, status not checked
    input  wire                     rvalid,
    output logic                    rready,
    input  l1_mem_pkg::beat_t       rdata,
    input  wire [1:0]               rresp,

    output logic                    busy
);

    localparam int CNT_W = $clog2(`RD_TRACK_DEPTH + 1);

    l1_mem_pkg::wr_state_e  wr_state;
    logic [CNT_W-1:0]       rd_cnt;
    logic                   ar_free;
    logic                   wr_ok;
    logic                   rd_ok;
    logic                   wr_accept;
    logic                   rd_accept;
    logic                   ar_fire;
    logic                   r_fire;

    // Reads wait behind a pending write, writes wait for all reads to drain
    assign ar_free = !arvalid || arready;
    assign wr_ok   = (wr_state == l1_mem_pkg::WR_IDLE) && !arvalid && (rd_cnt == '0);
    assign rd_ok   = (wr_state == l1_mem_pkg::WR_IDLE) && ar_free;

    assign up.req_ready = up.req_rw ? wr_ok : rd_ok;
    assign wr_accept    = up.req_valid && up.req_rw && wr_ok;
    assign rd_accept    = up.req_valid && !up.req_rw && rd_ok;

    //////////////////////////////////////////////////
    // Write FSM

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_state <= l1_mem_pkg::WR_IDLE;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
        end else begin
            case (wr_state)
                l1_mem_pkg::WR_IDLE: begin
                    if (wr_accept) begin
                        awvalid  <= 1'b1;
                        wvalid   <= 1'b1;
                        wr_state <= l1_mem_pkg::WR_SEND;
                    end
                end
                l1_mem_pkg::WR_SEND: begin
                    // AW and W may complete in either order
                    awvalid <= awvalid && !awready;
                    wvalid  <= wvalid && !wready;
                    if ((!awvalid || awready) && (!wvalid || wready)) begin
                        wr_state <= l1_mem_pkg::WR_RESP;
                    end
                end
                l1_mem_pkg::WR_RESP: begin
                    if (bvalid) begin
                        wr_state <= l1_mem_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= l1_mem_pkg::WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            awaddr <= up.req_addr;
            wdata  <= up.req_data;
            wstrb  <= up.req_strb;
        end
        if (rd_accept) begin
            araddr <= up.req_addr;
        end
    end

    assign bready = (wr_state == l1_mem_pkg::WR_RESP);

    //////////////////////////////////////////////////
    // Read slot and in-flight count

    assign ar_fire = arvalid && arready;
    assign r_fire  = rvalid && rready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            arvalid <= 1'b0;
            rd_cnt  <= '0;
        end else begin
            if (ar_free) begin
                arvalid <= rd_accept;
            end
            case ({ar_fire, r_fire})
                2'b10:   rd_cnt <= rd_cnt + 1'b1;
                2'b01:   rd_cnt <= rd_cnt - 1'b1;
                default: rd_cnt <= rd_cnt;
            endcase
        end
    end

    assign up.rsp_valid = rvalid;
    assign up.rsp_data  = rdata;
    assign rready       = up.rsp_ready;

    assign busy = (wr_state != l1_mem_pkg::WR_IDLE) || arvalid || (rd_cnt != '0);

endmodule

`default_nettype wire

// File: design/socket_mem_bridge.sv
// Socket memory bridge from two L1 client ports to one AXI4-Lite master
`default_nettype none

module socket_mem_bridge (
    input  wire                     clk,
    input  wire                     arst_n,

    // Instruction cache client
    input  wire                     ic_req_valid,
    input  l1_mem_pkg::addr_t       ic_req_addr,
    output logic                    ic_req_ready,
    output logic                    ic_rsp_valid,
    output l1_mem_pkg::word_t       ic_rsp_data,
    input  wire                     ic_rsp_ready,

    // Data cache client
    input  wire                     dc_req_valid,
    input  wire                     dc_req_rw,
    input  l1_mem_pkg::addr_t       dc_req_addr,
    input  l1_mem_pkg::word_strb_t  dc_req_byteen,
    input  l1_mem_pkg::word_t       dc_req_data,
    output logic                    dc_req_ready,
    output logic                    dc_rsp_valid,
    output l1_mem_pkg::word_t       dc_rsp_data,
    input  wire                     dc_rsp_ready,

    // AXI4-Lite master
    output logic                    awvalid,
    input  wire                     awready,
    output l1_mem_pkg::addr_t       awaddr,
    output logic                    wvalid,
    input  wire                     wready,
    output l1_mem_pkg::beat_t       wdata,
    output l1_mem_pkg::beat_strb_t  wstrb,
    input  wire                     bvalid,
    output logic                    bready,
    input  wire [1:0]               bresp,
    output logic                    arvalid,
    input  wire                     arready,
    output l1_mem_pkg::addr_t       araddr,
    input  wire                     rvalid,
    output logic                    rready,
    input  l1_mem_pkg::beat_t       rdata,
    input  wire [1:0]               rresp,

    output logic                    busy
);

    mem_word_if word_bus ();
    mem_beat_if beat_bus ();

    l1_mem_arb u_arb (
        .ic_req_valid  (ic_req_valid),
        .ic_req_addr   (ic_req_addr),
        .ic_req_ready  (ic_req_ready),
        .ic_rsp_valid  (ic_rsp_valid),
        .ic_rsp_data   (ic_rsp_data),
        .ic_rsp_ready  (ic_rsp_ready),
        .dc_req_valid  (dc_req_valid),
        .dc_req_rw     (dc_req_rw),
        .dc_req_addr   (dc_req_addr),
        .dc_req_byteen (dc_req_byteen),
        .dc_req_data   (dc_req_data),
        .dc_req_ready  (dc_req_ready),
        .dc_rsp_valid  (dc_rsp_valid),
        .dc_rsp_data   (dc_rsp_data),
        .dc_rsp_ready  (dc_rsp_ready),
        .down          (word_bus.arb)
    );

    l1_mem_adapter u_adapter (
        .clk    (clk),
        .arst_n (arst_n),
        .up     (word_bus.adapter),
        .down   (beat_bus.adapter)
    );

    axi_lite_master u_axi (
        .clk     (clk),
        .arst_n  (arst_n),
        .up      (beat_bus.master),
        .awvalid (awvalid),
        .awready (awready),
        .awaddr  (awaddr),
        .wvalid  (wvalid),
        .wready  (wready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .bvalid  (bvalid),
        .bready  (bready),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arready (arready),
        .araddr  (araddr),
        .rvalid  (rvalid),
        .rready  (rready),
        .rdata   (rdata),
        .rresp   (rresp),
        .busy    (busy)
    );

endmodule

`default_nettype wire

// File: tests/bridge_sva.sv
// AXI4-Lite handshake and ordering assertions bound into the socket memory bridge
`default_nettype none

module bridge_sva (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                awvalid,
    input  wire                awready,
    input  l1_mem_pkg::addr_t  awaddr,
    input  wire                wvalid,
    input  wire                wready,
    input  l1_mem_pkg::beat_t  wdata,
    input  wire                bready,
    input  wire                arvalid,
    input  wire                arready,
    input  l1_mem_pkg::addr_t  araddr
);

    // Valid and payload hold until the slave takes them
    aw_stable: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("AW dropped or changed before awready");

    w_stable: assert property (@(posedge clk) disable iff (!arst_n)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else $error("W dropped or changed before wready");

    ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("AR dropped or changed before arready");

    // A write is open from AW/W until its B handshake
    no_read_in_write: assert property (@(posedge clk) disable iff (!arst_n)
        (awvalid || wvalid || bready) |-> !(arvalid && arready))
        else $error("AR handshake while a write is unfinished");

    reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !awvalid && !wvalid && !arvalid)
        else $error("Channel valid high during reset");

endmodule

bind socket_mem_bridge bridge_sva u_sva (
    .clk     (clk),
    .arst_n  (arst_n),
    .awvalid (awvalid),
    .awready (awready),
    .awaddr  (awaddr),
    .wvalid  (wvalid),
    .wready  (wready),
    .wdata   (wdata),
    .bready  (bready),
    .arvalid (arvalid),
    .arready (arready),
    .araddr  (araddr)
);

`default_nettype wire

// File: tests/bridge_checker.sv
// Scoreboard that follows client requests and checks AXI beats and client responses
`default_nettype none

module bridge_checker (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     ic_req_valid,
    input  l1_mem_pkg::addr_t       ic_req_addr,
    input  wire                     ic_req_ready,
    input  wire                     ic_rsp_valid,
    input  l1_mem_pkg::word_t       ic_rsp_data,
    input  wire                     ic_rsp_ready,
    input  wire                     dc_req_valid,
    input  wire                     dc_req_rw,
    input  l1_mem_pkg::addr_t       dc_req_addr,
    input  l1_mem_pkg::word_strb_t  dc_req_byteen,
    input  l1_mem_pkg::word_t       dc_req_data,
    input  wire                     dc_req_ready,
    input  wire                     dc_rsp_valid,
    input  l1_mem_pkg::word_t       dc_rsp_data,
    input  wire                     dc_rsp_ready,
    input  wire                     awvalid,
    input  wire                     awready,
    input  l1_mem_pkg::addr_t       awaddr,
    input  wire                     wvalid,
    input  wire                     wready,
    input  l1_mem_pkg::beat_t       wdata,
    input  l1_mem_pkg::beat_strb_t  wstrb,
    input  wire                     bready,
    input  wire                     arvalid,
    input  wire                     arready,
    input  l1_mem_pkg::addr_t       araddr,
    input  wire                     rready,
    input  wire                     busy,
    input  wire                     idle_chk,
    input  wire                     report,
    output int                      err_total
);

    l1_mem_pkg::word_t  ref_mem [l1_mem_pkg::addr_t];
    l1_mem_pkg::word_t  ic_q [$];
    l1_mem_pkg::word_t  dc_q [$];
    l1_mem_pkg::addr_t  ar_q [$];
    l1_mem_pkg::addr_t  aw_q [$];
    // Expected strobes over both data halves
    logic [71:0]        w_q [$];
    int                 checks [1:5];
    int                 errs [1:5];
    string              names [1:5];

    initial begin
        names[1] = "lane steering";
        names[2] = "read-after-write data";
        names[3] = "instruction reads in order";
        names[4] = "priority";
        names[5] = "reset and idle";
        for (int t = 1; t <= 5; t++) begin
            checks[t] = 0;
            errs[t] = 0;
        end
    end

    // Same fill as the slave memory, a function of the whole address
    function automatic l1_mem_pkg::word_t fill_word(l1_mem_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic l1_mem_pkg::word_t ref_word(l1_mem_pkg::addr_t a);
        l1_mem_pkg::addr_t key;
        key = {a[31:2], 2'b00};
        if (ref_mem.exists(key)) begin
            return ref_mem[key];
        end
        return fill_word(key);
    endfunction

    function automatic l1_mem_pkg::addr_t beat_addr(l1_mem_pkg::addr_t a);
        return {a[31:3], 3'b000};
    endfunction

    task automatic merge_word(l1_mem_pkg::addr_t a, l1_mem_pkg::word_strb_t be,
                              l1_mem_pkg::word_t d);
        l1_mem_pkg::word_t w;
        w = ref_word(a);
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        ref_mem[{a[31:2], 2'b00}] = w;
    endtask

    task automatic compare(int t, string name, logic [63:0] exp, logic [63:0] got);
        checks[t]++;
        if (exp !== got) begin
            errs[t]++;
            $display("Mismatch %s: expected 0x%0h, got 0x%0h", name, exp, got);
        end
    endtask

    task automatic fail_check(int t, string msg);
        checks[t]++;
        errs[t]++;
        $display("Error: %s", msg);
    endtask

    //////////////////////////////////////////////////
    // Handshakes sampled mid-cycle, one half period before they complete

    always @(negedge clk) begin
        if (arst_n) begin
            // Accepted requests still owed a handshake keep the bridge busy
            if (ic_q.size() + dc_q.size() + aw_q.size() + w_q.size() != 0) begin
                compare(5, "busy", 64'(1), 64'(busy));
            end
            if (ic_req_valid && dc_req_valid) begin
                compare(4, "dc_req_ready", 64'(0), 64'(dc_req_ready));
            end
            if (ic_req_valid && ic_req_ready) begin
                ar_q.push_back(beat_addr(ic_req_addr));
                ic_q.push_back(ref_word(ic_req_addr));
            end
            if (dc_req_valid && dc_req_ready) begin
                if (dc_req_rw) begin
                    aw_q.push_back(beat_addr(dc_req_addr));
                    w_q.push_back({dc_req_addr[2] ? {dc_req_byteen, 4'h0}
                                                  : {4'h0, dc_req_byteen},
                                   dc_req_data, dc_req_data});
                    merge_word(dc_req_addr, dc_req_byteen, dc_req_data);
                end else begin
                    ar_q.push_back(beat_addr(dc_req_addr));
                    dc_q.push_back(ref_word(dc_req_addr));
                end
            end
            if (awvalid && awready) begin
                if (aw_q.size() == 0) begin
                    fail_check(1, "AW handshake without an accepted write");
                end else begin
                    compare(1, "awaddr", 64'(aw_q.pop_front()), 64'(awaddr));
                end
            end
            if (wvalid && wready) begin
                if (w_q.size() == 0) begin
                    fail_check(1, "W handshake without an accepted write");
                end else begin
                    compare(1, "wstrb", 64'(w_q[0][71:64]), 64'(wstrb));
                    compare(1, "wdata", w_q[0][63:0], wdata);
                    void'(w_q.pop_front());
                end
            end
            if (arvalid && arready) begin
                if (ar_q.size() == 0) begin
                    fail_check(4, "AR handshake without an accepted read");
                end else begin
                    compare(4, "araddr", 64'(ar_q.pop_front()), 64'(araddr));
                end
            end
            // The owning client's rsp_ready is passed straight to rready
            if (ic_rsp_valid) begin
                compare(3, "rready", 64'(ic_rsp_ready), 64'(rready));
            end
            if (dc_rsp_valid) begin
                compare(2, "rready", 64'(dc_rsp_ready), 64'(rready));
            end
            if (ic_rsp_valid && ic_rsp_ready) begin
                if (ic_q.size() == 0) begin
                    fail_check(3, "instruction response with no read outstanding");
                end else begin
                    compare(3, "ic_rsp_data", 64'(ic_q.pop_front()), 64'(ic_rsp_data));
                end
            end
            if (dc_rsp_valid && dc_rsp_ready) begin
                if (dc_q.size() == 0) begin
                    fail_check(2, "data response with no read outstanding");
                end else begin
                    compare(2, "dc_rsp_data", 64'(dc_q.pop_front()), 64'(dc_rsp_data));
                end
            end
        end
        if (idle_chk) begin
            compare(5, "busy", 64'(0), 64'(busy));
            compare(5, "awvalid", 64'(0), 64'(awvalid));
            compare(5, "wvalid", 64'(0), 64'(wvalid));
            compare(5, "bready", 64'(0), 64'(bready));
            compare(5, "arvalid", 64'(0), 64'(arvalid));
            compare(5, "ic_rsp_valid", 64'(0), 64'(ic_rsp_valid));
            compare(5, "dc_rsp_valid", 64'(0), 64'(dc_rsp_valid));
            if (ic_q.size() + dc_q.size() + ar_q.size() + aw_q.size() + w_q.size() != 0) begin
                fail_check(5, "requests left over after the traffic drained");
            end
        end
    end

    always @(posedge report) begin
        err_total = 0;
        for (int t = 1; t <= 5; t++) begin
            $display("Test %0d %s: %0d checks, %0d errors", t, names[t], checks[t], errs[t]);
            err_total += errs[t];
        end
        $display("Totals: %0d checks, %0d errors",
                 checks[1] + checks[2] + checks[3] + checks[4] + checks[5], err_total);
    end

endmodule

`default_nettype wire

// File: tests/tb_socket_mem_bridge.sv
// Testbench for the socket memory bridge with random clients and an AXI4-Lite slave model
`default_nettype none

module tb_socket_mem_bridge;

    localparam int NUM_REQ   = 150;
    // Every client request counts as one test in the watchdog budget
    localparam int WATCHDOG  = 2 * NUM_REQ * 200;
    localparam int WIN_WORDS = 16;
    localparam l1_mem_pkg::addr_t WIN_BASE = 32'h0000_2000;

    logic clk;
    logic arst_n;
    logic ic_req_valid, ic_req_ready, ic_rsp_valid, ic_rsp_ready;
    l1_mem_pkg::addr_t ic_req_addr;
    l1_mem_pkg::word_t ic_rsp_data;
    logic dc_req_valid, dc_req_rw, dc_req_ready, dc_rsp_valid, dc_rsp_ready;
    l1_mem_pkg::addr_t dc_req_addr;
    l1_mem_pkg::word_strb_t dc_req_byteen;
    l1_mem_pkg::word_t dc_req_data, dc_rsp_data;
    logic awvalid, awready, wvalid, wready, bvalid, bready, arvalid, arready, rvalid, rready;
    l1_mem_pkg::addr_t awaddr, araddr;
    l1_mem_pkg::beat_t wdata, rdata;
    l1_mem_pkg::beat_strb_t wstrb;
    logic [1:0] bresp, rresp;
    logic busy, idle_chk, report;
    int err_total;

    // Slave model state
    l1_mem_pkg::beat_t mem [l1_mem_pkg::addr_t];
    l1_mem_pkg::beat_t rd_q [$];
    l1_mem_pkg::addr_t aw_addr;
    l1_mem_pkg::addr_t ar_addr;
    l1_mem_pkg::beat_t w_data;
    l1_mem_pkg::beat_strb_t w_strb;
    logic have_aw, have_w, b_pend, done;
    logic ic_fire, dc_fire, aw_fire, w_fire, b_fire, ar_fire, r_fire;
    int b_wait, ic_sent, dc_sent;

    socket_mem_bridge u_socket_mem_bridge (.*);
    bridge_checker u_chk (.*);

    function automatic l1_mem_pkg::word_t fill_word(l1_mem_pkg::addr_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5a5a_a5a5;
    endfunction

    function automatic l1_mem_pkg::beat_t read_beat(l1_mem_pkg::addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {fill_word(a + 32'd4), fill_word(a)};
    endfunction

    function automatic logic coin(int unsigned pct);
        return ($urandom % 100) < pct;
    endfunction

    function automatic l1_mem_pkg::addr_t rand_addr();
        return WIN_BASE + l1_mem_pkg::addr_t'(($urandom % WIN_WORDS) * 4);
    endfunction

    task automatic write_beat(l1_mem_pkg::addr_t a, l1_mem_pkg::beat_t d,
                              l1_mem_pkg::beat_strb_t s);
        l1_mem_pkg::beat_t b;
        b = read_beat(a);
        for (int i = 0; i < 8; i++) begin
            if (s[i]) begin
                b[8*i +: 8] = d[8*i +: 8];
            end
        end
        mem[a] = b;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        $display("Timeout: traffic did not drain within %0d cycles", WATCHDOG);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////////////////////////
    // One cycle of clients and slave, driven just after the edge

    task automatic step_traffic();
        if (ic_fire) ic_req_valid = 1'b0;
        if (!ic_req_valid && ic_sent < NUM_REQ && coin(35)) begin
            ic_req_valid = 1'b1;
            ic_req_addr  = rand_addr();
            ic_sent++;
        end
        if (dc_fire) dc_req_valid = 1'b0;
        if (!dc_req_valid && dc_sent < NUM_REQ && coin(45)) begin
            dc_req_valid  = 1'b1;
            dc_req_rw     = coin(50);
            dc_req_addr   = rand_addr();
            dc_req_byteen = l1_mem_pkg::word_strb_t'($urandom_range(15, 1));
            dc_req_data   = $urandom;
            dc_sent++;
        end
        if (aw_fire) begin
            aw_addr = awaddr;
            have_aw = 1'b1;
        end
        if (w_fire) begin
            w_data = wdata;
            w_strb = wstrb;
            have_w = 1'b1;
        end
        if (have_aw && have_w) begin
            write_beat(aw_addr, w_data, w_strb);
            have_aw = 1'b0;
            have_w  = 1'b0;
            b_pend  = 1'b1;
            b_wait  = int'($urandom % 4);
        end
        if (b_fire) bvalid = 1'b0;
        if (b_pend) begin
            if (b_wait == 0) begin
                bvalid = 1'b1;
                b_pend = 1'b0;
            end else begin
                b_wait--;
            end
        end
        if (ar_fire) rd_q.push_back(read_beat(ar_addr));
        if (r_fire) rvalid = 1'b0;
        if (!rvalid && rd_q.size() != 0 && coin(50)) begin
            rvalid = 1'b1;
            rdata  = rd_q.pop_front();
        end
        awready      = coin(60);
        wready       = coin(60);
        arready      = coin(60);
        ic_rsp_ready = coin(70);
        dc_rsp_ready = coin(70);
    endtask

    initial begin
        void'($urandom(90));
        arst_n = 1'b0;
        {ic_req_valid, ic_rsp_ready, dc_req_valid, dc_req_rw, dc_rsp_ready} = '0;
        {awready, wready, bvalid, arready, rvalid, idle_chk, report} = '0;
        ic_req_addr = '0;
        dc_req_addr = '0;
        dc_req_byteen = '0;
        dc_req_data = '0;
        rdata = '0;
        bresp = 2'b00;
        rresp = 2'b00;
        {have_aw, have_w, b_pend, done} = '0;
        b_wait = 0;
        ic_sent = 0;
        dc_sent = 0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        idle_chk = 1'b1;
        @(posedge clk);
        #1 idle_chk = 1'b0;
        while (!done) begin
            @(negedge clk);
            ic_fire = ic_req_valid && ic_req_ready;
            dc_fire = dc_req_valid && dc_req_ready;
            aw_fire = awvalid && awready;
            w_fire  = wvalid && wready;
            b_fire  = bvalid && bready;
            ar_fire = arvalid && arready;
            // The AR slot may reload with the next read at the same edge
            ar_addr = araddr;
            r_fire  = rvalid && rready;
            done = (ic_sent == NUM_REQ) && (dc_sent == NUM_REQ) && !ic_req_valid
                && !dc_req_valid && !busy && !rvalid && !bvalid && !b_pend
                && (rd_q.size() == 0);
            @(posedge clk);
            #1;
            step_traffic();
        end
        idle_chk = 1'b1;
        @(posedge clk);
        #1 idle_chk = 1'b0;
        report = 1'b1;
        #1;
        if (err_total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
design/l1_mem_pkg.sv
design/l1_mem_ifs.sv
design/l1_mem_arb.sv
design/l1_mem_adapter.sv
design/axi_lite_master.sv
design/socket_mem_bridge.sv
tests/bridge_sva.sv
tests/bridge_checker.sv
tests/tb_socket_mem_bridge.sv

// File: run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_socket_mem_bridge \
    -f sources.f --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "FAIL: see errors above" sim.log; then
    exit 1
fi
exit 0
